/* div_pkg.sv */
`default_nettype none

package div_pkg;

    ////////////////////////////////////////
    // Widths

    // Operand and result width
    localparam int XLEN = 32;

    // Instruction id width, four ids in flight
    localparam int ID_WIDTH = 2;

    ////////////////////////////////////////
    // Operation encoding

    // Bit 0 marks unsigned, bit 1 selects the remainder
    typedef enum logic [1:0] {
        DIV  = 2'b00,
        DIVU = 2'b01,
        REM  = 2'b10,
        REMU = 2'b11
    } div_op_t;

    ////////////////////////////////////////
    // Request as carried through the queue

    // 2 + 1 + 32 + 32 + 2 = 69 bits
    typedef struct packed {
        div_op_t             op;
        // Take last quotient and remainder, skip the divider
        logic                reuse;
        logic [XLEN-1:0]     rs1;
        logic [XLEN-1:0]     rs2;
        logic [ID_WIDTH-1:0] id;
    } div_request_t;

endpackage

`default_nettype wire

/* div_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module div_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  logic     pop,
    input  payload_t data_in,
    output payload_t data_out,
    output logic     valid,
    output logic     full
);

    // Pointer width, DEPTH is a power of two
    localparam int PTR_W = $clog2(DEPTH);

    payload_t           mem [DEPTH];
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W-1:0]   wr_ptr;
    // One extra bit so a full queue is distinct from an empty one
    logic [PTR_W:0]     count;
    logic               do_push;
    logic               do_pop;

    ////////////////////////////////////////
    // Qualified requests

    // Writes into a full queue are dropped
    assign do_push = push & ~full;
    // Pops on an empty queue are dropped
    assign do_pop  = pop & valid;

    ////////////////////////////////////////
    // Pointers and occupancy

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap on their own
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            // Simultaneous push and pop leaves count alone
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= data_in;
    end

    ////////////////////////////////////////
    // Status and head

    assign valid = (count != '0);
    assign full  = (count == (PTR_W + 1)'(DEPTH));

    // Head entry shown without a pop
    assign data_out = mem[rd_ptr];

endmodule

`default_nettype wire

/* div_core.sv */
`timescale 1ns/1ps
`default_nettype none

module div_core #(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  logic [WIDTH-1:0] dividend,
    input  logic [WIDTH-1:0] divisor,
    output logic [WIDTH-1:0] quotient,
    output logic [WIDTH-1:0] remainder,
    output logic             complete,
    output logic             divisor_zero
);

    localparam int CNT_W = $clog2(WIDTH);

    logic               busy;
    logic [CNT_W-1:0]   count;
    logic [WIDTH-1:0]   quot_reg;
    logic [WIDTH-1:0]   rem_reg;
    logic [WIDTH-1:0]   divisor_reg;
    logic               zero_reg;
    logic               step;
    logic               last_step;
    logic [WIDTH:0]     shifted;
    logic [WIDTH+1:0]   trial;
    logic               trial_neg;

    ////////////////////////////////////////
    // Iteration control

    // One bit per cycle between start and complete
    assign step      = busy & ~complete;
    assign last_step = step & (count == CNT_W'(WIDTH - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            count    <= '0;
            complete <= 1'b0;
        end else begin
            // Complete is a single-cycle pulse
            complete <= last_step;
            if (start && !busy) begin
                busy  <= 1'b1;
                count <= '0;
            end else if (step) begin
                count <= count + 1'b1;
            end else if (complete) begin
                // Free again once the result has been announced
                busy <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Restoring shift-subtract

    // Partial remainder with next dividend bit shifted in
    assign shifted = {rem_reg, quot_reg[WIDTH-1]};
    // Extra top bit acts as the borrow
    assign trial     = {1'b0, shifted} - {2'b00, divisor_reg};
    assign trial_neg = trial[WIDTH+1];

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            // Dividend bits shift out of the quotient register
            quot_reg    <= dividend;
            rem_reg     <= '0;
            divisor_reg <= divisor;
            zero_reg    <= (divisor == '0);
        end else if (step) begin
            quot_reg <= {quot_reg[WIDTH-2:0], ~trial_neg};
            // Restore on borrow, otherwise keep the difference
            if (trial_neg)
                rem_reg <= shifted[WIDTH-1:0];
            else
                rem_reg <= trial[WIDTH-1:0];
        end
    end

    ////////////////////////////////////////
    // Results

    // Zero divisor yields all ones and the dividend without special casing
    assign quotient     = quot_reg;
    assign remainder    = rem_reg;
    assign divisor_zero = zero_reg;

endmodule

`default_nettype wire

/* div_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module div_unit import div_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                push,
    input  div_request_t        request,
    input  logic [ID_WIDTH-1:0] read_id,
    output logic                full,
    output logic                done,
    output logic [ID_WIDTH-1:0] done_id,
    output logic [XLEN-1:0]     read_data
);

    div_request_t    head;
    logic            head_valid;
    logic            core_complete;
    logic            in_progress;
    logic            start_core;
    logic            signed_op;
    logic            rem_op;
    logic            dividend_neg;
    logic            divisor_neg;
    logic            quotient_neg;
    logic            remainder_neg;
    logic [XLEN-1:0] dividend_mag;
    logic [XLEN-1:0] divisor_mag;
    logic [XLEN-1:0] quotient;
    logic [XLEN-1:0] remainder;
    logic            divisor_zero;
    logic            negate_result;
    logic [XLEN-1:0] selected;
    logic [XLEN-1:0] result;
    logic [XLEN-1:0] rd_bank [2**ID_WIDTH];

    ////////////////////////////////////////
    // Request queue

    div_fifo #(
        .payload_t (div_request_t),
        .DEPTH     (FIFO_DEPTH)
    ) u_request_fifo (
        .clk      (clk),
        .rst      (rst),
        .push     (push),
        .pop      (done),
        .data_in  (request),
        .data_out (head),
        .valid    (head_valid),
        .full     (full)
    );

    ////////////////////////////////////////
    // Control

    // Reuse requests never touch the core
    assign start_core = head_valid & ~in_progress & ~head.reuse;
    // Reuse completes as soon as it reaches the head
    assign done    = core_complete | (head_valid & head.reuse);
    assign done_id = head.id;

    // Blocks a second start for the head still being divided
    always_ff @(posedge clk) begin
        if (rst)
            in_progress <= 1'b0;
        else if (start_core)
            in_progress <= 1'b1;
        else if (core_complete)
            in_progress <= 1'b0;
    end

    ////////////////////////////////////////
    // Signs and magnitudes

    assign signed_op = ~head.op[0];
    assign rem_op    = head.op[1];

    assign dividend_neg  = signed_op & head.rs1[XLEN-1];
    assign divisor_neg   = signed_op & head.rs2[XLEN-1];
    // Quotient sign from both operands
    assign quotient_neg  = dividend_neg ^ divisor_neg;
    // Remainder follows the dividend
    assign remainder_neg = dividend_neg;

    // Most negative value maps to its unsigned magnitude
    assign dividend_mag = dividend_neg ? (XLEN'(0) - head.rs1) : head.rs1;
    assign divisor_mag  = divisor_neg ? (XLEN'(0) - head.rs2) : head.rs2;

    ////////////////////////////////////////
    // Divider

    div_core #(
        .WIDTH (XLEN)
    ) u_div_core (
        .clk          (clk),
        .rst          (rst),
        .start        (start_core),
        .dividend     (dividend_mag),
        .divisor      (divisor_mag),
        .quotient     (quotient),
        .remainder    (remainder),
        .complete     (core_complete),
        .divisor_zero (divisor_zero)
    );

    ////////////////////////////////////////
    // Result select and sign fix

    assign selected = rem_op ? remainder : quotient;
    // All-ones quotient of x/0 stays all ones
    assign negate_result = rem_op ? remainder_neg : (quotient_neg & ~divisor_zero);
    assign result = negate_result ? (XLEN'(0) - selected) : selected;

    ////////////////////////////////////////
    // Result bank

    always_ff @(posedge clk) begin
        if (done)
            rd_bank[head.id] <= result;
    end

    // Combinational read by id
    assign read_data = rd_bank[read_id];

endmodule

`default_nettype wire

/* issue_port.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_port import div_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                req,
    input  div_op_t             op,
    input  logic                reuse,
    input  logic [XLEN-1:0]     rs1,
    input  logic [XLEN-1:0]     rs2,
    input  logic [ID_WIDTH-1:0] id,
    input  logic                full,
    output logic                ack,
    output logic                push,
    output div_request_t        request
);

    // Handshake phase
    typedef enum logic {
        PH_IDLE  = 1'b0,
        PH_ACKED = 1'b1
    } phase_t;

    phase_t phase;
    logic   accept;

    ////////////////////////////////////////
    // Four-phase receiver

    // Take data only while there is room in the queue
    assign accept = (phase == PH_IDLE) & req & ~full;

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= PH_IDLE;
            push  <= 1'b0;
        end else begin
            // Push for the single cycle after acceptance
            push <= accept;
            case (phase)
                PH_IDLE: begin
                    if (accept)
                        phase <= PH_ACKED;
                end
                PH_ACKED: begin
                    // Wait for the sender to drop req
                    if (!req)
                        phase <= PH_IDLE;
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

    // Ack is the phase itself, registered
    assign ack = (phase == PH_ACKED);

    // Captured copy, sender lines are free after ack
    always_ff @(posedge clk) begin
        if (accept) begin
            request.op    <= op;
            request.reuse <= reuse;
            request.rs1   <= rs1;
            request.rs2   <= rs2;
            request.id    <= id;
        end
    end

endmodule

`default_nettype wire

/* div_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module div_subsystem import div_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                clk,
    input  logic                rst,
    // Issue side
    input  logic                req,
    input  div_op_t             op,
    input  logic                reuse,
    input  logic [XLEN-1:0]     rs1,
    input  logic [XLEN-1:0]     rs2,
    input  logic [ID_WIDTH-1:0] id,
    output logic                ack,
    // Result side
    input  logic [ID_WIDTH-1:0] read_id,
    output logic                done,
    output logic [ID_WIDTH-1:0] done_id,
    output logic [XLEN-1:0]     read_data
);

    logic         push;
    logic         full;
    div_request_t request;

    ////////////////////////////////////////
    // Handshake front end

    issue_port u_issue_port (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .op      (op),
        .reuse   (reuse),
        .rs1     (rs1),
        .rs2     (rs2),
        .id      (id),
        .full    (full),
        .ack     (ack),
        .push    (push),
        .request (request)
    );

    ////////////////////////////////////////
    // Divide unit and result bank

    div_unit #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_div_unit (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .request   (request),
        .read_id   (read_id),
        .full      (full),
        .done      (done),
        .done_id   (done_id),
        .read_data (read_data)
    );

endmodule

`default_nettype wire

/* tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 4
) (
    output logic clk
);

    // Free-running clock, low at time zero
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

/* div_subsystem_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module div_subsystem_checker import div_pkg::*; (
    input logic                clk,
    input logic                rst,
    input logic                req,
    input logic                ack,
    input logic                push,
    input logic [ID_WIDTH-1:0] push_id,
    input logic                done,
    input logic [ID_WIDTH-1:0] done_id
);

    // Far deeper than the ids that can be in flight
    localparam int ORDER_DEPTH = 16;

    logic [ID_WIDTH-1:0] order_mem [ORDER_DEPTH];
    logic [3:0]          wr_ptr;
    logic [3:0]          rd_ptr;

    ////////////////////////////////////////
    // Issue order of pushed ids

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (done)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            order_mem[wr_ptr] <= push_id;
    end

    ////////////////////////////////////////
    // Handshake and completion rules

    // Ack only answers a raised req
    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> $past(req))
        else $error("ack rose while req was low");

    // One push per accepted request
    push_one_cycle: assert property (@(posedge clk) disable iff (rst)
        push |=> !push)
        else $error("push held high for more than one cycle");

    // Oldest pushed id completes first
    done_in_order: assert property (@(posedge clk) disable iff (rst)
        done |-> (done_id == order_mem[rd_ptr]))
        else $error("done_id out of issue order");

endmodule

bind div_subsystem div_subsystem_checker u_div_subsystem_checker (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .ack     (ack),
    .push    (push),
    .push_id (request.id),
    .done    (done),
    .done_id (done_id)
);

`default_nettype wire

/* div_subsystem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module div_subsystem_tb
    import div_pkg::*;
();

    // Each case line holds op, reuse, rs1, rs2 and expected
    localparam int          WORDS        = 5;
    localparam int          MAX_CASES    = 40;
    localparam int          RANDOM_CASES = 16;
    // Op column value closing the case list
    localparam logic [31:0] END_MARK     = 32'h0000_00ff;

    logic                clk;
    logic                rst;
    logic                req;
    div_op_t             op;
    logic                reuse;
    logic [XLEN-1:0]     rs1;
    logic [XLEN-1:0]     rs2;
    logic [ID_WIDTH-1:0] id;
    logic                ack;
    logic [ID_WIDTH-1:0] read_id;
    logic                done;
    logic [ID_WIDTH-1:0] done_id;
    logic [XLEN-1:0]     read_data;

    logic [31:0]         case_words [WORDS*MAX_CASES];
    integer              seed;
    int                  file_cases;
    int                  cycle_count;
    int                  cycle_limit = 1000000;
    int                  errors;
    int                  checks;
    int                  issued;
    int                  completed;
    int                  backpressure_seen;
    int                  last_done_cycle;

    // Requests acked but not yet done in issue order
    logic [ID_WIDTH-1:0] pend_id [$];
    logic [XLEN-1:0]     pend_expected [$];
    logic                pend_reuse [$];
    int                  pend_case [$];

    // Bank read scheduled for the next falling edge
    logic                read_pending;
    logic [XLEN-1:0]     read_expected;
    int                  read_case;

    tb_clock #(
        .PERIOD_NS (4)
    ) u_tb_clock (
        .clk (clk)
    );

    div_subsystem #(
        .FIFO_DEPTH (4)
    ) u_div_subsystem (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .op        (op),
        .reuse     (reuse),
        .rs1       (rs1),
        .rs2       (rs2),
        .id        (id),
        .ack       (ack),
        .read_id   (read_id),
        .done      (done),
        .done_id   (done_id),
        .read_data (read_data)
    );

    ////////////////////////////////////////
    // Helpers

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("CHECK FAILED t=%0t %s got=%h expected=%h", $time, name, got, expected);
        end
    endtask

    // RISC-V divide rules with zero divisor and overflow handled first
    function automatic logic [XLEN-1:0] expected_result(input logic [1:0] op_code,
                                                       input logic [XLEN-1:0] a,
                                                       input logic [XLEN-1:0] b);
        logic is_unsigned;
        logic is_rem;
        is_unsigned = op_code[0];
        is_rem      = op_code[1];
        if (b == '0)
            return is_rem ? a : '1;
        if (!is_unsigned && a == {1'b1, {(XLEN-1){1'b0}}} && b == '1)
            return is_rem ? '0 : a;
        if (is_unsigned)
            return is_rem ? (a % b) : (a / b);
        // Signed operators truncate toward zero
        return is_rem ? XLEN'($signed(a) % $signed(b)) : XLEN'($signed(a) / $signed(b));
    endfunction

    // Four-phase request that returns with ack low again
    task automatic issue_request(input logic [1:0] op_code, input logic reuse_flag,
                                 input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                                 input logic [XLEN-1:0] expected, input int index);
        int wait_cycles;
        req         = 1'b1;
        op          = div_op_t'(op_code);
        reuse       = reuse_flag;
        rs1         = a;
        rs2         = b;
        id          = ID_WIDTH'(index);
        wait_cycles = 0;
        do begin
            @(negedge clk);
            wait_cycles++;
        end while (!ack);
        // Full queue holds ack back
        if (wait_cycles > 1)
            backpressure_seen = 1;
        pend_id.push_back(id);
        pend_expected.push_back(expected);
        pend_reuse.push_back(reuse_flag);
        pend_case.push_back(index);
        issued++;
        req = 1'b0;
        do
            @(negedge clk);
        while (ack);
    endtask

    task automatic record_completion();
        int idx;
        int i;
        idx = -1;
        for (i = 0; i < pend_id.size(); i++) begin
            if (idx < 0 && pend_id[i] == done_id)
                idx = i;
        end
        if (idx < 0) begin
            errors++;
            $display("Done for id %0d at %0t with no request outstanding", done_id, $time);
        end else begin
            check_value("completion_position", idx, 0);
            // Reuse skips the core so done follows the previous one directly
            if (pend_reuse[idx])
                check_value("reuse_done_gap", cycle_count - last_done_cycle, 1);
            read_id       = done_id;
            read_expected = pend_expected[idx];
            read_case     = pend_case[idx];
            read_pending  = 1'b1;
            pend_id.delete(idx);
            pend_expected.delete(idx);
            pend_reuse.delete(idx);
            pend_case.delete(idx);
            completed++;
        end
        last_done_cycle = cycle_count;
    endtask

    ////////////////////////////////////////
    // Completion monitor

    always @(negedge clk) begin
        if (!rst) begin
            // Bank written on the edge after done
            if (read_pending) begin
                check_value($sformatf("read_data case %0d", read_case), read_data,
                            read_expected);
                read_pending = 1'b0;
            end
            if (done)
                record_completion();
        end
    end

    ////////////////////////////////////////
    // Watchdog

    initial begin
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, %0d of %0d requests done",
                 cycle_count, completed, issued);
        $display("TEST FAILED");
        $finish;
    end

    ////////////////////////////////////////
    // Stimulus

    initial begin
        int i;
        int base;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [31:0]     draw;
        logic [1:0]      op_code;
        rst = 1'b1;
        req = 1'b0;
        op = DIV;
        reuse = 1'b0;
        rs1 = '0;
        rs2 = '0;
        id = '0;
        read_id = '0;
        seed = 32'h580c;
        errors = 0;
        checks = 0;
        issued = 0;
        completed = 0;
        backpressure_seen = 0;
        last_done_cycle = 0;
        read_pending = 1'b0;
        read_expected = '0;
        read_case = 0;
        // Unread entries look like the end mark
        for (i = 0; i < WORDS * MAX_CASES; i++)
            case_words[i] = END_MARK;
        $readmemh("div_cases.txt", case_words);
        file_cases = 0;
        while (file_cases < MAX_CASES && case_words[file_cases * WORDS] !== END_MARK)
            file_cases++;
        cycle_limit = (file_cases + RANDOM_CASES) * (XLEN + 8) + 50;
        if (file_cases == 0) begin
            errors++;
            $display("No cases found in div_cases.txt");
        end
        repeat (2) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        // Cases from the file issued back to back
        for (i = 0; i < file_cases; i++) begin
            base = i * WORDS;
            issue_request(case_words[base][1:0], case_words[base + 1][0],
                          case_words[base + 2], case_words[base + 3],
                          case_words[base + 4], i);
        end

        // Random operands with some reshaped toward corner cases
        for (i = 0; i < RANDOM_CASES; i++) begin
            a       = $random(seed);
            b       = $random(seed);
            draw    = $random(seed);
            op_code = draw[1:0];
            case (i % 8)
                1: b = b >> 24;
                3: b = b >> 12;
                5: b = '0;
                7: begin
                    a = 32'h8000_0000;
                    b = '1;
                end
                default: ;
            endcase
            issue_request(op_code, 1'b0, a, b, expected_result(op_code, a, b),
                          file_cases + i);
        end

        while (completed < issued)
            @(negedge clk);
        // Last bank read
        repeat (2) @(negedge clk);

        check_value("backpressure_seen", backpressure_seen, 1);

        $display("%0d checks, %0d errors, %0d of %0d requests done",
                 checks, errors, completed, issued);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* div_cases.txt */
// Columns in hex: op reuse rs1 rs2 expected
// op 0 DIV, 1 DIVU, 2 REM, 3 REMU; a line with op ff ends the list
// Unsigned quotients and remainders
1 0 00000064 00000007 0000000e
3 0 00000064 00000007 00000002
1 0 ffffffff 00000010 0fffffff
3 0 ffffffff 00000010 0000000f
1 0 12345678 00001000 00012345
3 0 12345678 00001000 00000678
1 0 00000005 0000000a 00000000
3 0 00000005 0000000a 00000005
1 0 80000000 ffffffff 00000000
3 0 80000000 ffffffff 80000000
// Signed, all four sign combinations
0 0 00000007 00000002 00000003
2 0 00000007 00000002 00000001
0 0 fffffff9 00000002 fffffffd
2 0 fffffff9 00000002 ffffffff
0 0 00000007 fffffffe fffffffd
2 0 00000007 fffffffe 00000001
0 0 fffffff9 fffffffe 00000003
2 0 fffffff9 fffffffe ffffffff
0 0 fffff000 00000030 ffffffab
2 0 fffff000 00000030 fffffff0
// Divide by zero and signed overflow
0 0 00000123 00000000 ffffffff
1 0 00000123 00000000 ffffffff
2 0 fffffff9 00000000 fffffff9
3 0 fffffff9 00000000 fffffff9
0 0 80000000 ffffffff 80000000
2 0 80000000 ffffffff 00000000
// Remainder taken from the previous quotient run
0 0 000003e8 fffffff9 ffffff72
2 1 000003e8 fffffff9 00000006
0 0 fffffc18 00000007 ffffff72
2 1 fffffc18 00000007 fffffffa
1 0 0000abcd 00000010 00000abc
3 1 0000abcd 00000010 0000000d
ff 0 00000000 00000000 00000000

/* tb.f */
div_pkg.sv
div_fifo.sv
div_core.sv
div_unit.sv
issue_port.sv
div_subsystem.sv
tb_clock.sv
div_subsystem_checker.sv
div_subsystem_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the divide unit testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 -f tb.f --top-module div_subsystem_tb -o sim_div \
    && ./obj_dir/sim_div 2>&1 | tee sim.log \
    || { echo "Build or simulation ended abnormally"; exit 1; }

grep -q "TEST FAILED" sim.log && { echo "Simulation reported a failure"; exit 1; }
grep -q "TEST OK" sim.log || { echo "Simulation log has no result"; exit 1; }
echo "Simulation passed"
